// ==== vision_pkg.sv ====
package vision_pkg;

   ////////////////////
   // Datapath widths
   ////////////////////
   localparam int PIXEL_WIDTH     = 16;
   localparam int PIXELS_PER_WORD = 4;   // Pixels packed per DMA beat
   localparam int DMA_DATA_WIDTH  = 64;

   localparam int APB_ADDR_WIDTH  = 16;
   localparam int APB_DATA_WIDTH  = 32;

   typedef logic [PIXEL_WIDTH-1:0]    pixel_t;
   typedef logic [DMA_DATA_WIDTH-1:0] dma_word_t;

   // Buffered word with payload and frame marker
   typedef struct packed {
      logic      last;   // Word holds the last pixel of a frame
      dma_word_t data;
   } cam_word_t;

   ////////////////////
   // CSR map
   ////////////////////
   localparam logic [APB_ADDR_WIDTH-1:0] CSR_CTRL_ADDR   = 16'h0000;  // Bit 0 capture enable
   localparam logic [APB_ADDR_WIDTH-1:0] CSR_FRAMES_ADDR = 16'h0004;  // Read only
   localparam logic [APB_ADDR_WIDTH-1:0] CSR_DROPS_ADDR  = 16'h0008;  // Read only
   localparam logic [APB_ADDR_WIDTH-1:0] CSR_ID_ADDR     = 16'h000C;  // Read only

   localparam logic [APB_DATA_WIDTH-1:0] VISION_ID = 32'h5649_0001;

endpackage

// ==== cam_pixel_packer.sv ====
`timescale 1ns/1ps

module cam_pixel_packer #(
   parameter int PIXELS_PER_WORD = vision_pkg::PIXELS_PER_WORD
) (
   input  logic                  i_pixel_clk,
   input  logic                  i_arst_n,
   input  logic                  i_enable,       // Capture enable from CSR
   input  logic                  i_pixel_valid,
   input  vision_pkg::pixel_t    i_pixel_data,
   input  logic                  i_pixel_eof,    // Last pixel of frame
   input  logic                  i_fifo_full,
   output logic                  o_push,
   output vision_pkg::cam_word_t o_word,
   output logic                  o_drop
);

   import vision_pkg::*;

   localparam int LANE_W = (PIXELS_PER_WORD > 1) ? $clog2(PIXELS_PER_WORD) : 1;

   logic [LANE_W-1:0]            lane_q;       // Next lane to fill
   pixel_t [PIXELS_PER_WORD-1:0] asm_q;        // Word under assembly
   pixel_t [PIXELS_PER_WORD-1:0] asm_next;
   logic                         sample;
   logic                         word_end;
   logic                         word_rdy_q;   // Finished word waiting for push or drop
   cam_word_t                    word_q;

   // Source cannot stall so pixels outside enable are lost
   assign sample   = i_pixel_valid & i_enable;
   assign word_end = (lane_q == LANE_W'(PIXELS_PER_WORD - 1)) | i_pixel_eof;

   // Insert current pixel and clear lanes above it
   always_comb begin
      for (int i = 0; i < PIXELS_PER_WORD; i++) begin
         if (i < lane_q) begin
            asm_next[i] = asm_q[i];
         end else if (i == lane_q) begin
            asm_next[i] = i_pixel_data;
         end else begin
            asm_next[i] = '0;   // Zero fill for short words
         end
      end
   end

   always_ff @(posedge i_pixel_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         lane_q     <= '0;
         word_rdy_q <= 1'b0;
      end else begin
         word_rdy_q <= sample & word_end;
         if (sample) begin
            if (word_end) begin
               lane_q <= '0;
            end else begin
               lane_q <= lane_q + LANE_W'(1);
            end
         end
      end
   end

   always_ff @(posedge i_pixel_clk) begin
      if (sample) begin
         if (word_end) begin
            word_q.data <= asm_next;
            word_q.last <= i_pixel_eof;
         end else begin
            asm_q <= asm_next;
         end
      end
   end

   // Full is checked on the push cycle itself
   assign o_word = word_q;
   assign o_push = word_rdy_q & ~i_fifo_full;
   assign o_drop = word_rdy_q & i_fifo_full;

   // Frame marker only rides on a valid pixel
   a_eof_needs_valid: assert property (@(posedge i_pixel_clk) disable iff (!i_arst_n)
      i_pixel_eof |-> i_pixel_valid);

endmodule

// ==== cam_word_fifo.sv ====
`timescale 1ns/1ps

module cam_word_fifo #(
   parameter type payload_t = logic [64:0],
   parameter int  DEPTH     = 16
) (
   input  logic     i_pixel_clk,
   input  logic     i_arst_n,
   input  logic     i_push,
   input  payload_t i_data,
   input  logic     i_pop,
   output payload_t o_data,        // Head word
   output logic     o_full,
   output logic     o_not_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;      // Occupancy
   logic             wr_en;
   logic             rd_en;

   // Pointer advance wraps at DEPTH so any depth works
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + PTR_W'(1);
   endfunction

   assign wr_en = i_push & ~o_full;
   assign rd_en = i_pop & o_not_empty;

   ////////////////////
   // Pointers and count
   ////////////////////
   always_ff @(posedge i_pixel_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (rd_en) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         if (wr_en && !rd_en) begin
            count_q <= count_q + 1'b1;
         end else if (rd_en && !wr_en) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge i_pixel_clk) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= i_data;
      end
   end

   assign o_data      = mem[rd_ptr_q];   // Visible the cycle after push
   assign o_full      = (count_q == (PTR_W + 1)'(DEPTH));
   assign o_not_empty = (count_q != '0);

   // Clients must respect the flags
   a_no_push_full: assert property (@(posedge i_pixel_clk) disable iff (!i_arst_n)
      !(i_push && o_full));

   a_no_pop_empty: assert property (@(posedge i_pixel_clk) disable iff (!i_arst_n)
      !(i_pop && !o_not_empty));

endmodule

// ==== cam_dma_writer.sv ====
`timescale 1ns/1ps

module cam_dma_writer (
   input  logic                  i_pixel_clk,
   input  logic                  i_arst_n,
   input  logic                  i_not_empty,
   input  vision_pkg::cam_word_t i_word,
   input  logic                  i_cam_dma_wready,
   output logic                  o_pop,
   output logic                  o_cam_dma_wvalid,
   output logic                  o_cam_dma_wlast,
   output vision_pkg::dma_word_t o_cam_dma_wdata,
   output logic                  o_frame_done
);

   import vision_pkg::*;

   logic      valid_q;
   logic      last_q;
   logic      done_q;
   dma_word_t data_q;
   logic      accept;   // Beat taken by DMA this cycle
   logic      load;     // Refill from FIFO head

   assign accept = valid_q & i_cam_dma_wready;
   assign load   = i_not_empty & (~valid_q | i_cam_dma_wready);

   ////////////////////
   // Output register
   ////////////////////
   always_ff @(posedge i_pixel_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         valid_q <= 1'b0;
         last_q  <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= accept & last_q;   // One pulse per finished frame
         if (load) begin
            valid_q <= 1'b1;
            last_q  <= i_word.last;
         end else if (accept) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_pixel_clk) begin
      if (load) begin
         data_q <= i_word.data;
      end
   end

   assign o_pop            = load;
   assign o_cam_dma_wvalid = valid_q;
   assign o_cam_dma_wlast  = last_q;
   assign o_cam_dma_wdata  = data_q;
   assign o_frame_done     = done_q;

endmodule

// ==== vision_csr_apb.sv ====
`timescale 1ns/1ps

module vision_csr_apb (
   input  logic                                  i_pixel_clk,
   input  logic                                  i_arst_n,
   // APB3 slave
   input  logic                                  i_psel,
   input  logic                                  i_penable,
   input  logic                                  i_pwrite,
   input  logic [vision_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
   input  logic [vision_pkg::APB_DATA_WIDTH-1:0] i_pwdata,
   output logic                                  o_pready,
   output logic [vision_pkg::APB_DATA_WIDTH-1:0] o_prdata,
   output logic                                  o_pslverr,
   // Capture control and status
   output logic                                  o_enable,
   input  logic                                  i_frame_done,
   input  logic                                  i_drop
);

   import vision_pkg::*;

   logic                      access;     // APB access phase
   logic                      addr_hit;
   logic                      wr_ctrl;
   logic                      enable_q;
   logic [APB_DATA_WIDTH-1:0] frames_q;
   logic [APB_DATA_WIDTH-1:0] drops_q;
   logic [APB_DATA_WIDTH-1:0] rdata;

   assign access  = i_psel & i_penable;
   assign wr_ctrl = access & i_pwrite & (i_paddr == CSR_CTRL_ADDR);

   ////////////////////
   // Address decode
   ////////////////////
   always_comb begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (i_paddr)
         CSR_CTRL_ADDR: begin
            rdata = {{(APB_DATA_WIDTH - 1){1'b0}}, enable_q};
         end
         CSR_FRAMES_ADDR: begin
            rdata = frames_q;
         end
         CSR_DROPS_ADDR: begin
            rdata = drops_q;
         end
         CSR_ID_ADDR: begin
            rdata = VISION_ID;
         end
         default: begin
            addr_hit = 1'b0;   // Outside the register map
         end
      endcase
   end

   ////////////////////
   // Registers
   ////////////////////
   always_ff @(posedge i_pixel_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         enable_q <= 1'b0;
         frames_q <= '0;
         drops_q  <= '0;
      end else begin
         if (wr_ctrl) begin
            enable_q <= i_pwdata[0];
         end
         // Both counters wrap
         if (i_frame_done) begin
            frames_q <= frames_q + 1'b1;
         end
         if (i_drop) begin
            drops_q <= drops_q + 1'b1;
         end
      end
   end

   assign o_pready  = 1'b1;                 // Zero wait states
   assign o_prdata  = rdata;
   assign o_pslverr = access & ~addr_hit;
   assign o_enable  = enable_q;

endmodule

// ==== vision_cam_top.sv ====
`timescale 1ns/1ps

module vision_cam_top #(
   parameter int FIFO_DEPTH = 16   // Words buffered ahead of the DMA
) (
   input  logic                                  i_pixel_clk,
   input  logic                                  i_arst_n,
   // Camera pixel stream
   input  logic                                  i_pixel_valid,
   input  vision_pkg::pixel_t                    i_pixel_data,
   input  logic                                  i_pixel_eof,
   // APB3 control
   input  logic                                  i_psel,
   input  logic                                  i_penable,
   input  logic                                  i_pwrite,
   input  logic [vision_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
   input  logic [vision_pkg::APB_DATA_WIDTH-1:0] i_pwdata,
   output logic                                  o_pready,
   output logic [vision_pkg::APB_DATA_WIDTH-1:0] o_prdata,
   output logic                                  o_pslverr,
   // Camera DMA write stream
   input  logic                                  i_cam_dma_wready,
   output logic                                  o_cam_dma_wvalid,
   output logic                                  o_cam_dma_wlast,
   output vision_pkg::dma_word_t                 o_cam_dma_wdata
);

   import vision_pkg::*;

   logic      enable;
   logic      push;
   logic      drop;
   logic      fifo_full;
   logic      fifo_not_empty;
   logic      pop;
   logic      frame_done;
   cam_word_t packed_word;   // Packer to FIFO
   cam_word_t head_word;     // FIFO to writer

   cam_pixel_packer #(
      .PIXELS_PER_WORD ( PIXELS_PER_WORD )
   ) u_packer (
      .i_pixel_clk   ( i_pixel_clk   ),
      .i_arst_n      ( i_arst_n      ),
      .i_enable      ( enable        ),
      .i_pixel_valid ( i_pixel_valid ),
      .i_pixel_data  ( i_pixel_data  ),
      .i_pixel_eof   ( i_pixel_eof   ),
      .i_fifo_full   ( fifo_full     ),
      .o_push        ( push          ),
      .o_word        ( packed_word   ),
      .o_drop        ( drop          )
   );

   cam_word_fifo #(
      .payload_t ( cam_word_t ),
      .DEPTH     ( FIFO_DEPTH )
   ) u_fifo (
      .i_pixel_clk ( i_pixel_clk    ),
      .i_arst_n    ( i_arst_n       ),
      .i_push      ( push           ),
      .i_data      ( packed_word    ),
      .i_pop       ( pop            ),
      .o_data      ( head_word      ),
      .o_full      ( fifo_full      ),
      .o_not_empty ( fifo_not_empty )
   );

   cam_dma_writer u_writer (
      .i_pixel_clk      ( i_pixel_clk      ),
      .i_arst_n         ( i_arst_n         ),
      .i_not_empty      ( fifo_not_empty   ),
      .i_word           ( head_word        ),
      .i_cam_dma_wready ( i_cam_dma_wready ),
      .o_pop            ( pop              ),
      .o_cam_dma_wvalid ( o_cam_dma_wvalid ),
      .o_cam_dma_wlast  ( o_cam_dma_wlast  ),
      .o_cam_dma_wdata  ( o_cam_dma_wdata  ),
      .o_frame_done     ( frame_done       )
   );

   // Control and status registers
   vision_csr_apb u_csr (
      .i_pixel_clk  ( i_pixel_clk ),
      .i_arst_n     ( i_arst_n    ),
      .i_psel       ( i_psel      ),
      .i_penable    ( i_penable   ),
      .i_pwrite     ( i_pwrite    ),
      .i_paddr      ( i_paddr     ),
      .i_pwdata     ( i_pwdata    ),
      .o_pready     ( o_pready    ),
      .o_prdata     ( o_prdata    ),
      .o_pslverr    ( o_pslverr   ),
      .o_enable     ( enable      ),
      .i_frame_done ( frame_done  ),
      .i_drop       ( drop        )
   );

endmodule

// ==== tb_vision_cam.sv ====
`timescale 1ns/1ps

module tb_vision_cam;

   import vision_pkg::*;

   localparam int FIFO_DEPTH = 16;
   localparam int WAIT_LIMIT = 4000;   // Cycles before any wait gives up

   typedef pixel_t    pixel_list_t[$];
   typedef cam_word_t word_list_t[$];

   logic                      clk = 1'b0;
   logic                      arst_n;
   logic                      pixel_valid;
   pixel_t                    pixel_data;
   logic                      pixel_eof;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [APB_ADDR_WIDTH-1:0] paddr;
   logic [APB_DATA_WIDTH-1:0] pwdata;
   logic                      pready;
   logic [APB_DATA_WIDTH-1:0] prdata;
   logic                      pslverr;
   logic                      dma_wready;
   logic                      dma_wvalid;
   logic                      dma_wlast;
   dma_word_t                 dma_wdata;

   integer    seed = 32'h86ae_a612;
   int        ready_mode = 2;    // 0 random, 1 held low, 2 held high
   cam_word_t exp_q[$];          // Beats still expected from the DMA side
   cam_word_t rx_beat;
   int        rx_count = 0;

   vision_cam_top #(
      .FIFO_DEPTH ( FIFO_DEPTH )
   ) uut (
      .i_pixel_clk      ( clk         ),
      .i_arst_n         ( arst_n      ),
      .i_pixel_valid    ( pixel_valid ),
      .i_pixel_data     ( pixel_data  ),
      .i_pixel_eof      ( pixel_eof   ),
      .i_psel           ( psel        ),
      .i_penable        ( penable     ),
      .i_pwrite         ( pwrite      ),
      .i_paddr          ( paddr       ),
      .i_pwdata         ( pwdata      ),
      .o_pready         ( pready      ),
      .o_prdata         ( prdata      ),
      .o_pslverr        ( pslverr     ),
      .i_cam_dma_wready ( dma_wready  ),
      .o_cam_dma_wvalid ( dma_wvalid  ),
      .o_cam_dma_wlast  ( dma_wlast   ),
      .o_cam_dma_wdata  ( dma_wdata   )
   );

   always #4 clk = ~clk;   // 8 ns period

   ////////////////////
   // Failure reporting
   ////////////////////
   task automatic end_with_failure();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic report_error(input string msg);
      $display("ERROR @ %0t ns: %s", $time, msg);
      end_with_failure();
   endtask

   task automatic report_stall(input string what);
      $display("Timed out waiting for %s, the design stalled", what);
      end_with_failure();
   endtask

   task automatic check_word(input cam_word_t got, input cam_word_t exp);
      if (got !== exp) begin
         report_error($sformatf("beat %0d got last=%0b data=%h, expected last=%0b data=%h",
                                rx_count, got.last, got.data, exp.last, exp.data));
      end
   endtask

   task automatic check_reg(input string name, input logic [APB_DATA_WIDTH-1:0] got,
                            input logic [APB_DATA_WIDTH-1:0] exp);
      if (got !== exp) begin
         report_error($sformatf("%s read %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_error($sformatf("%s is %b, expected %b", name, got, exp));
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////
   // First pixel in the low lane and short words zero padded
   function automatic word_list_t ref_pack(input pixel_list_t px, input bit eof_at_end);
      word_list_t words;
      cam_word_t  w;
      int         lane;
      bit         eof;
      w    = '0;
      lane = 0;
      foreach (px[i]) begin
         eof = eof_at_end && (i == px.size() - 1);
         w.data[lane*PIXEL_WIDTH +: PIXEL_WIDTH] = px[i];
         if ((lane == PIXELS_PER_WORD - 1) || eof) begin
            w.last = eof;
            words.push_back(w);
            w    = '0;
            lane = 0;
         end else begin
            lane++;
         end
      end
      return words;
   endfunction

   task automatic make_pixels(input int n, output pixel_list_t px);
      px = {};
      repeat (n) begin
         px.push_back(pixel_t'($random(seed)));
      end
   endtask

   task automatic queue_expected(input word_list_t words, input int n);
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(words[i]);
      end
   endtask

   // Camera source sends one pixel per cycle without stalls
   task automatic send_pixels(input pixel_list_t px, input bit eof_at_end);
      foreach (px[i]) begin
         @(negedge clk);
         pixel_valid = 1'b1;
         pixel_data  = px[i];
         pixel_eof   = eof_at_end && (i == px.size() - 1);
      end
      @(negedge clk);
      pixel_valid = 1'b0;
      pixel_eof   = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_stall("the expected DMA beats");
         end
      end
   endtask

   ////////////////////
   // APB3 master
   ////////////////////
   task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [APB_DATA_WIDTH-1:0] wdata,
                             output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
      int cycles;
      @(negedge clk);
      psel    = 1'b1;   // Setup phase
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      cycles  = 0;
      @(posedge clk);
      while (!pready) begin
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            report_stall("APB pready");
         end
         @(posedge clk);
      end
      if (cycles != 0) begin
         report_error($sformatf("APB access to %h took %0d wait states", addr, cycles));
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_expect(input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [APB_DATA_WIDTH-1:0] exp, input string name);
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      apb_access(1'b0, addr, '0, rd, err);
      check_flag({name, " pslverr"}, err, 1'b0);
      check_reg(name, rd, exp);
   endtask

   task automatic write_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] data, input logic exp_err);
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      apb_access(1'b1, addr, data, rd, err);
      check_flag($sformatf("pslverr on write to %h", addr), err, exp_err);
   endtask

   // DMA side back-pressure
   always @(negedge clk) begin
      case (ready_mode)
         0:       dma_wready = ($random(seed) & 32'h1) != 0;
         1:       dma_wready = 1'b0;
         default: dma_wready = 1'b1;
      endcase
   end

   // Accepted beats go to the compare task
   always @(posedge clk) begin
      if (arst_n && dma_wvalid && dma_wready) begin
         rx_beat.last = dma_wlast;
         rx_beat.data = dma_wdata;
         if (exp_q.size() == 0) begin
            report_error($sformatf("unexpected DMA beat with data %h", dma_wdata));
         end else begin
            check_word(rx_beat, exp_q.pop_front());
            rx_count++;
         end
      end
   end

   initial begin
      pixel_list_t               px;
      word_list_t                words;
      logic [APB_DATA_WIDTH-1:0] drops_before;
      logic [APB_DATA_WIDTH-1:0] rd;
      logic                      err;
      arst_n      = 1'b0;
      pixel_valid = 1'b0;
      pixel_data  = '0;
      pixel_eof   = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      dma_wready  = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Reset values
      check_flag("wvalid after reset", dma_wvalid, 1'b0);
      read_expect(CSR_CTRL_ADDR, '0, "CTRL");
      read_expect(CSR_FRAMES_ADDR, '0, "FRAMES");
      read_expect(CSR_DROPS_ADDR, '0, "DROPS");
      read_expect(CSR_ID_ADDR, VISION_ID, "ID");

      // Full words under random back-pressure
      write_reg(CSR_CTRL_ADDR, 32'h1, 1'b0);
      ready_mode = 0;
      make_pixels(32, px);
      words = ref_pack(px, 1'b1);
      queue_expected(words, words.size());
      send_pixels(px, 1'b1);
      wait_drain();

      // Short last word
      make_pixels(13, px);
      words = ref_pack(px, 1'b1);
      queue_expected(words, words.size());
      send_pixels(px, 1'b1);
      wait_drain();
      read_expect(CSR_FRAMES_ADDR, 32'd2, "FRAMES after two frames");

      // Nothing may reach the DMA while capture is disabled
      write_reg(CSR_CTRL_ADDR, 32'h0, 1'b0);
      make_pixels(20, px);
      send_pixels(px, 1'b1);
      repeat (FIFO_DEPTH) @(negedge clk);
      check_flag("wvalid while capture disabled", dma_wvalid, 1'b0);
      write_reg(CSR_CTRL_ADDR, 32'h1, 1'b0);
      make_pixels(24, px);
      words = ref_pack(px, 1'b1);
      queue_expected(words, words.size());
      send_pixels(px, 1'b1);
      wait_drain();
      read_expect(CSR_FRAMES_ADDR, 32'd3, "FRAMES after re-enable");

      // Only the FIFO and the output register survive an overflow
      apb_access(1'b0, CSR_DROPS_ADDR, '0, drops_before, err);
      ready_mode = 1;
      @(negedge clk);
      make_pixels((FIFO_DEPTH + 5) * PIXELS_PER_WORD, px);
      words = ref_pack(px, 1'b1);
      queue_expected(words, FIFO_DEPTH + 1);
      send_pixels(px, 1'b1);
      read_expect(CSR_DROPS_ADDR, drops_before + 32'd4, "DROPS after overflow");
      check_flag("wvalid under back-pressure", dma_wvalid, 1'b1);
      ready_mode = 0;
      wait_drain();
      @(negedge clk);
      check_flag("wvalid after overflow drain", dma_wvalid, 1'b0);
      read_expect(CSR_FRAMES_ADDR, 32'd3, "FRAMES after overflow");

      // Address errors and read-only ID
      apb_access(1'b0, 16'h0010, '0, rd, err);
      check_flag("pslverr on read of 0010", err, 1'b1);
      write_reg(16'h0010, 32'hFFFF_FFFF, 1'b1);
      write_reg(CSR_ID_ADDR, 32'h0, 1'b0);
      read_expect(CSR_ID_ADDR, VISION_ID, "ID after write");

      if (exp_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         report_error("DMA beats still outstanding at end of test");
      end
   end

endmodule

// ==== files.f ====
vision_pkg.sv
cam_pixel_packer.sv
cam_word_fifo.sv
cam_dma_writer.sv
vision_csr_apb.sv
vision_cam_top.sv
tb_vision_cam.sv

// ==== Bender.yml ====
package:
  name: vision_cam

sources:
  - vision_pkg.sv
  - cam_pixel_packer.sv
  - cam_word_fifo.sv
  - cam_dma_writer.sv
  - vision_csr_apb.sv
  - vision_cam_top.sv
  - target: simulation
    files:
      - tb_vision_cam.sv
